/* hdl/lane_operand_top.sv */
// Lane operand path joining the requester, the operand queues and the adder
`timescale 1ns/1ps
`include "opq_cfg.svh"

module lane_operand_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               vrf_we_i,
  input  opq_pkg::vaddr_t    vrf_waddr_i,
  input  opq_pkg::elen_t     vrf_wdata_i,
  input  opq_pkg::vadd_cmd_t cmd_i,
  input  logic               cmd_valid_i,
  output logic               cmd_ready_o,
  output opq_pkg::elen_t     result_o,
  output logic               result_valid_o,
  input  logic               result_ready_i
);

  opq_pkg::operand_queue_cmd_t [`OPQ_NR_OPQ-1:0] opq_cmd;
  logic                                          opq_cmd_valid;
  opq_pkg::elen_t [`OPQ_NR_OPQ-1:0]              req_operand;
  opq_pkg::elen_t [`OPQ_NR_OPQ-1:0]              opq_operand;
  logic [`OPQ_NR_OPQ-1:0]                        req_operand_valid;
  logic [`OPQ_NR_OPQ-1:0]                        operand_issued;
  logic [`OPQ_NR_OPQ-1:0]                        opq_ready;
  logic [`OPQ_NR_OPQ-1:0]                        opq_valid;
  logic                                          operand_ready;
  opq_pkg::eew_e                                 add_sew;
  opq_pkg::vlen_t                                add_vl;
  logic                                          add_cmd_valid;

  operand_requester i_operand_requester (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .vrf_we_i             (vrf_we_i),
    .vrf_waddr_i          (vrf_waddr_i),
    .vrf_wdata_i          (vrf_wdata_i),
    .cmd_i                (cmd_i),
    .cmd_valid_i          (cmd_valid_i),
    .cmd_ready_o          (cmd_ready_o),
    .opq_cmd_o            (opq_cmd),
    .opq_cmd_valid_o      (opq_cmd_valid),
    .operand_o            (req_operand),
    .operand_valid_o      (req_operand_valid),
    .operand_issued_o     (operand_issued),
    .operand_queue_ready_i(opq_ready),
    .add_sew_o            (add_sew),
    .add_vl_o             (add_vl),
    .add_cmd_valid_o      (add_cmd_valid)
  );

  // One queue per source operand, all drained together
  for (genvar q = 0; q < `OPQ_NR_OPQ; q++) begin : gen_opq
    operand_queue i_operand_queue (
      .clk_i                    (clk_i),
      .rst_ni                   (rst_ni),
      .operand_queue_cmd_i      (opq_cmd[q]),
      .operand_queue_cmd_valid_i(opq_cmd_valid),
      .operand_i                (req_operand[q]),
      .operand_valid_i          (req_operand_valid[q]),
      .operand_issued_i         (operand_issued[q]),
      .operand_queue_ready_o    (opq_ready[q]),
      .operand_o                (opq_operand[q]),
      .operand_valid_o          (opq_valid[q]),
      .operand_ready_i          (operand_ready)
    );
  end

  vector_adder i_vector_adder (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .sew_i          (add_sew),
    .vl_i           (add_vl),
    .cmd_valid_i    (add_cmd_valid),
    .operand_a_i    (opq_operand[0]),
    .operand_b_i    (opq_operand[1]),
    .operand_valid_i(opq_valid),
    .operand_ready_o(operand_ready),
    .result_o       (result_o),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i)
  );

endmodule

/* hdl/operand_queue.sv */
// Operand queue with command buffer, credit guarded input buffer and widening
`timescale 1ns/1ps
`include "opq_cfg.svh"

module operand_queue (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // From the requester
  input  opq_pkg::operand_queue_cmd_t operand_queue_cmd_i,
  input  logic                        operand_queue_cmd_valid_i,
  input  opq_pkg::elen_t              operand_i,
  input  logic                        operand_valid_i,
  input  logic                        operand_issued_i,
  output logic                        operand_queue_ready_o,
  // To the adder
  output opq_pkg::elen_t              operand_o,
  output logic                        operand_valid_o,
  input  logic                        operand_ready_i
);

  localparam int unsigned ElenLog = $clog2(`OPQ_ELEN);

  opq_pkg::operand_queue_cmd_t cmd;
  logic                        cmd_pop;
  logic                        cmd_empty;

  opq_pkg::elen_t              ibuf_operand;
  logic                        ibuf_pop;
  logic                        ibuf_empty;

  opq_pkg::opq_credit_t        credit_d, credit_q;

  logic [1:0]                  shift;
  logic                        sext;
  logic [1:0]                  sel_d, sel_q;
  opq_pkg::vlen_t              elem_d, elem_q;
  opq_pkg::elen_t              conv_operand;

  //////////////////////////////
  // Buffers
  //////////////////////////////

  // One extra slot covers the command still issuing reads while earlier ones drain
  opq_fifo #(
    .DEPTH(`OPQ_BUFFER_DEPTH + 1),
    .WIDTH($bits(opq_pkg::operand_queue_cmd_t))
  ) i_cmd_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (operand_queue_cmd_valid_i),
    .data_i (operand_queue_cmd_i),
    .pop_i  (cmd_pop),
    .data_o (cmd),
    .empty_o(cmd_empty),
    .full_o (),
    .usage_o()
  );

  opq_fifo #(
    .DEPTH(`OPQ_BUFFER_DEPTH),
    .WIDTH(`OPQ_ELEN)
  ) i_input_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (operand_valid_i),
    .data_i (operand_i),
    .pop_i  (ibuf_pop),
    .data_o (ibuf_operand),
    .empty_o(ibuf_empty),
    .full_o (),
    .usage_o()
  );

  // Each issued read owns a slot until its word is popped
  assign credit_d = credit_q + opq_pkg::opq_credit_t'(operand_issued_i)
                             - opq_pkg::opq_credit_t'(ibuf_pop);
  assign operand_queue_ready_o = (credit_q < `OPQ_BUFFER_DEPTH);

  //////////////////////////////
  // Widening
  //////////////////////////////

  assign shift = opq_pkg::conv_shift(cmd.conv);
  assign sext  = (cmd.conv == opq_pkg::OpqConvSExt2) || (cmd.conv == opq_pkg::OpqConvSExt4);

  // Bit i of the output maps to an element of the selected slice
  always_comb begin : p_conv
    int unsigned      src_log;
    int unsigned      dst_log;
    int unsigned      base;
    int unsigned      elem;
    int unsigned      bit_in;
    logic             ext;
    logic [ElenLog-1:0] idx;
    src_log = 3 + cmd.eew;
    dst_log = src_log + shift;
    base    = int'(sel_q) << (ElenLog - shift);
    for (int i = 0; i < `OPQ_ELEN; i++) begin
      elem   = i >> dst_log;
      bit_in = i & ((1 << dst_log) - 1);
      ext    = (bit_in >= (1 << src_log));
      // Upper bits repeat the source msb
      if (ext) begin
        bit_in = (1 << src_log) - 1;
      end
      idx = ElenLog'(base + (elem << src_log) + bit_in);
      conv_operand[i] = ext ? (sext & ibuf_operand[idx]) : ibuf_operand[idx];
    end
  end

  //////////////////////////////
  // Element accounting
  //////////////////////////////

  always_comb begin : p_output
    ibuf_pop = 1'b0;
    cmd_pop  = 1'b0;
    sel_d    = sel_q;
    elem_d   = elem_q;

    operand_o       = conv_operand;
    operand_valid_o = !ibuf_empty && !cmd_empty;

    if (operand_valid_o && operand_ready_i) begin
      elem_d = elem_q + opq_pkg::vlen_t'(1 << (ElenLog - 3 - cmd.eew - shift));
      sel_d  = sel_q + 2'd1;
      // Last slice of the source word
      if (int'(sel_q) == (1 << shift) - 1) begin
        ibuf_pop = 1'b1;
        sel_d    = '0;
      end
      // Command done, drop a partial source word too
      if (elem_d >= cmd.vl) begin
        ibuf_pop = 1'b1;
        cmd_pop  = 1'b1;
        sel_d    = '0;
        elem_d   = '0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= '0;
      sel_q    <= '0;
      elem_q   <= '0;
    end else begin
      credit_q <= credit_d;
      sel_q    <= sel_d;
      elem_q   <= elem_d;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) credit_q <= `OPQ_BUFFER_DEPTH)
    else $error("Operand queue credit count above buffer depth");

endmodule

/* hdl/operand_requester.sv */
// Vector register file, command acceptance and per-queue operand read sequencing
`timescale 1ns/1ps
`include "opq_cfg.svh"

module operand_requester (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  // Register file preload
  input  logic                                          vrf_we_i,
  input  opq_pkg::vaddr_t                               vrf_waddr_i,
  input  opq_pkg::elen_t                                vrf_wdata_i,
  // Command
  input  opq_pkg::vadd_cmd_t                            cmd_i,
  input  logic                                          cmd_valid_i,
  output logic                                          cmd_ready_o,
  // Operand queues
  output opq_pkg::operand_queue_cmd_t [`OPQ_NR_OPQ-1:0] opq_cmd_o,
  output logic                                          opq_cmd_valid_o,
  output opq_pkg::elen_t [`OPQ_NR_OPQ-1:0]              operand_o,
  output logic [`OPQ_NR_OPQ-1:0]                        operand_valid_o,
  output logic [`OPQ_NR_OPQ-1:0]                        operand_issued_o,
  input  logic [`OPQ_NR_OPQ-1:0]                        operand_queue_ready_i,
  // Adder
  output opq_pkg::eew_e                                 add_sew_o,
  output opq_pkg::vlen_t                                add_vl_o,
  output logic                                          add_cmd_valid_o
);

  localparam int unsigned NrWords = `OPQ_NR_VREGS * `OPQ_WORDS_PER_VREG;

  opq_pkg::elen_t      vrf_q [NrWords];
  opq_pkg::req_state_e state_d, state_q;
  logic                cmd_take;

  opq_pkg::vreg_t      src_vs   [`OPQ_NR_OPQ];
  opq_pkg::opq_conv_e  src_conv [`OPQ_NR_OPQ];

  opq_pkg::vreg_t      rd_vs_q  [`OPQ_NR_OPQ];
  opq_pkg::vlen_t      rd_len_q [`OPQ_NR_OPQ];
  opq_pkg::vlen_t      rd_cnt_q [`OPQ_NR_OPQ];
  opq_pkg::vlen_t      rd_cnt_d [`OPQ_NR_OPQ];
  opq_pkg::vaddr_t     rd_addr  [`OPQ_NR_OPQ];
  logic [`OPQ_NR_OPQ-1:0] rd_done;

  always_ff @(posedge clk_i) begin
    if (vrf_we_i) begin
      vrf_q[vrf_waddr_i] <= vrf_wdata_i;
    end
  end

  //////////////////////////////
  // Command decode
  //////////////////////////////

  assign cmd_ready_o     = (state_q == opq_pkg::ReqIdle);
  assign cmd_take        = cmd_valid_i && cmd_ready_o;
  assign opq_cmd_valid_o = cmd_take;
  assign add_cmd_valid_o = cmd_take;
  assign add_sew_o       = cmd_i.sew;
  assign add_vl_o        = cmd_i.vl;

  // Queue 0 reads vs1, queue 1 reads vs2
  assign src_vs[0]   = cmd_i.vs1;
  assign src_vs[1]   = cmd_i.vs2;
  assign src_conv[0] = cmd_i.conv_a;
  assign src_conv[1] = cmd_i.conv_b;

  always_comb begin
    for (int q = 0; q < `OPQ_NR_OPQ; q++) begin
      opq_cmd_o[q].vl   = cmd_i.vl;
      opq_cmd_o[q].conv = src_conv[q];
      // Source width is narrower by the widening factor
      opq_cmd_o[q].eew  = opq_pkg::eew_e'(cmd_i.sew - opq_pkg::conv_shift(src_conv[q]));
    end
  end

  //////////////////////////////
  // Read sequencing
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    for (int q = 0; q < `OPQ_NR_OPQ; q++) begin
      operand_issued_o[q] = (state_q == opq_pkg::ReqBusy) &&
                            (rd_cnt_q[q] != rd_len_q[q]) && operand_queue_ready_i[q];
      rd_cnt_d[q] = rd_cnt_q[q] + opq_pkg::vlen_t'(operand_issued_o[q]);
      rd_done[q]  = (rd_cnt_d[q] == rd_len_q[q]);
      rd_addr[q]  = opq_pkg::vaddr_t'(rd_vs_q[q] * `OPQ_WORDS_PER_VREG + rd_cnt_q[q]);
    end
    if (cmd_take) begin
      state_d = opq_pkg::ReqBusy;
    end else if (state_q == opq_pkg::ReqBusy && &rd_done) begin
      state_d = opq_pkg::ReqIdle;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q         <= opq_pkg::ReqIdle;
      operand_valid_o <= '0;
      for (int q = 0; q < `OPQ_NR_OPQ; q++) begin
        rd_len_q[q] <= '0;
        rd_cnt_q[q] <= '0;
      end
    end else begin
      state_q         <= state_d;
      operand_valid_o <= operand_issued_o;
      for (int q = 0; q < `OPQ_NR_OPQ; q++) begin
        if (cmd_take) begin
          rd_len_q[q] <= opq_pkg::num_words(cmd_i.vl, opq_cmd_o[q].eew);
          rd_cnt_q[q] <= '0;
        end else begin
          rd_cnt_q[q] <= rd_cnt_d[q];
        end
      end
    end
  end

  // Register base and read data, one cycle behind the issue pulse
  always_ff @(posedge clk_i) begin
    for (int q = 0; q < `OPQ_NR_OPQ; q++) begin
      if (cmd_take) begin
        rd_vs_q[q] <= src_vs[q];
      end
      if (operand_issued_o[q]) begin
        operand_o[q] <= vrf_q[rd_addr[q]];
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) vrf_we_i |-> cmd_ready_o)
    else $error("Register file preload while operand reads are in flight");

endmodule

/* hdl/opq_cfg.svh */
// Sizing macros for the vector lane operand path
`ifndef OPQ_CFG_SVH
`define OPQ_CFG_SVH

// Datapath word width in bits
`define OPQ_ELEN 64

// Operand queues per lane
`define OPQ_NR_OPQ 2

// Entries in each operand queue input buffer
`define OPQ_BUFFER_DEPTH 2

// Register file geometry
`define OPQ_NR_VREGS 8
`define OPQ_WORDS_PER_VREG 4

`endif

/* hdl/opq_fifo.sv */
// Circular buffer FIFO with occupancy count
`timescale 1ns/1ps

module opq_fifo #(
  parameter int unsigned DEPTH = 2,
  parameter int unsigned WIDTH = 8
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       push_i,
  input  logic [WIDTH-1:0]           data_i,
  input  logic                       pop_i,
  output logic [WIDTH-1:0]           data_o,
  output logic                       empty_o,
  output logic                       full_o,
  output logic [$clog2(DEPTH+1)-1:0] usage_o
);

  localparam int unsigned PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [WIDTH-1:0]           mem_q [DEPTH];
  logic [PtrW-1:0]            rd_ptr_q, wr_ptr_q;
  logic [$clog2(DEPTH+1)-1:0] count_q;

  function automatic logic [PtrW-1:0] next_ptr(logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign data_o  = mem_q[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == DEPTH);
  assign usage_o = count_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o)
    else $error("FIFO overflow");
  assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> !empty_o)
    else $error("FIFO underflow");

endmodule

/* hdl/opq_pkg.sv */
// Width types, element width and conversion enums, command structs and helpers
`include "opq_cfg.svh"

package opq_pkg;

  // Meaningful widths
  typedef logic [`OPQ_ELEN-1:0] elen_t;
  typedef logic [4:0]           vaddr_t;
  typedef logic [2:0]           vreg_t;
  typedef logic [5:0]           vlen_t;
  typedef logic [1:0]           opq_credit_t;

  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } eew_e;

  typedef enum logic [2:0] {
    OpqConvNone,
    OpqConvSExt2,
    OpqConvZExt2,
    OpqConvSExt4,
    OpqConvZExt4
  } opq_conv_e;

  // Requester sequencing
  typedef enum logic {
    ReqIdle,
    ReqBusy
  } req_state_e;

  // External vector add command, sew is the destination width
  typedef struct packed {
    vreg_t     vs1;
    vreg_t     vs2;
    vlen_t     vl;
    eew_e      sew;
    opq_conv_e conv_a;
    opq_conv_e conv_b;
  } vadd_cmd_t;

  // Per queue command, eew is the source width
  typedef struct packed {
    vlen_t     vl;
    eew_e      eew;
    opq_conv_e conv;
  } operand_queue_cmd_t;

  // Adder bookkeeping entry
  typedef struct packed {
    eew_e  sew;
    vlen_t vl;
  } add_cmd_t;

  // Log2 of the widening factor
  function automatic logic [1:0] conv_shift(opq_conv_e conv);
    case (conv)
      OpqConvSExt2, OpqConvZExt2: return 2'd1;
      OpqConvSExt4, OpqConvZExt4: return 2'd2;
      default:                    return 2'd0;
    endcase
  endfunction

  // Words needed for vl elements of width ew, rounded up
  function automatic vlen_t num_words(vlen_t vl, eew_e ew);
    logic [8:0] bytes;
    bytes = 9'(vl) << ew;
    return vlen_t'((bytes + 9'd7) >> 3);
  endfunction

endpackage

/* hdl/vector_adder.sv */
// Elementwise adder draining the operand queues, with width FIFO and word counter
`timescale 1ns/1ps
`include "opq_cfg.svh"

module vector_adder (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  opq_pkg::eew_e          sew_i,
  input  opq_pkg::vlen_t         vl_i,
  input  logic                   cmd_valid_i,
  input  opq_pkg::elen_t         operand_a_i,
  input  opq_pkg::elen_t         operand_b_i,
  input  logic [`OPQ_NR_OPQ-1:0] operand_valid_i,
  output logic                   operand_ready_o,
  output opq_pkg::elen_t         result_o,
  output logic                   result_valid_o,
  input  logic                   result_ready_i
);

  opq_pkg::add_cmd_t wfifo_in;
  opq_pkg::add_cmd_t entry;
  logic              wfifo_empty;
  logic              wfifo_pop;
  opq_pkg::vlen_t    nr_words;
  opq_pkg::vlen_t    word_cnt_q;

  assign wfifo_in.sew = sew_i;
  assign wfifo_in.vl  = vl_i;

  // Sized like the queue command buffers
  opq_fifo #(
    .DEPTH(`OPQ_BUFFER_DEPTH + 1),
    .WIDTH($bits(opq_pkg::add_cmd_t))
  ) i_width_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (cmd_valid_i),
    .data_i (wfifo_in),
    .pop_i  (wfifo_pop),
    .data_o (entry),
    .empty_o(wfifo_empty),
    .full_o (),
    .usage_o()
  );

  assign result_valid_o  = &operand_valid_i && !wfifo_empty;
  assign operand_ready_o = result_valid_o && result_ready_i;
  assign nr_words        = opq_pkg::num_words(entry.vl, entry.sew);
  assign wfifo_pop       = operand_ready_o && (word_cnt_q + 1'b1 >= nr_words);

  // Wrapping sum per element
  always_comb begin : p_sum
    result_o = '0;
    case (entry.sew)
      opq_pkg::EW8:
        for (int e = 0; e < 8; e++) begin
          result_o[8*e +: 8] = operand_a_i[8*e +: 8] + operand_b_i[8*e +: 8];
        end
      opq_pkg::EW16:
        for (int e = 0; e < 4; e++) begin
          result_o[16*e +: 16] = operand_a_i[16*e +: 16] + operand_b_i[16*e +: 16];
        end
      opq_pkg::EW32:
        for (int e = 0; e < 2; e++) begin
          result_o[32*e +: 32] = operand_a_i[32*e +: 32] + operand_b_i[32*e +: 32];
        end
      default: result_o = operand_a_i + operand_b_i;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      word_cnt_q <= '0;
    end else if (operand_ready_o) begin
      word_cnt_q <= wfifo_pop ? '0 : word_cnt_q + 1'b1;
    end
  end

endmodule

/* src.f */
+incdir+hdl
+incdir+verification
hdl/opq_pkg.sv
hdl/opq_fifo.sv
hdl/operand_requester.sv
hdl/operand_queue.sv
hdl/vector_adder.sv
hdl/lane_operand_top.sv
verification/tb_lane_operand_top.sv

/* verification/tb_lane_model.svh */
// Reference model of the lane operand path: widening, elementwise sum and word count
`ifndef TB_LANE_MODEL_SVH
`define TB_LANE_MODEL_SVH

typedef opq_pkg::elen_t vrf_image_t [`OPQ_NR_VREGS * `OPQ_WORDS_PER_VREG];

// Low n bits set, n from 1 to 64
function automatic logic [63:0] low_mask(input int n);
  return {64{1'b1}} >> (64 - n);
endfunction

function automatic int widen_factor(input opq_pkg::opq_conv_e conv);
  case (conv)
    opq_pkg::OpqConvSExt2, opq_pkg::OpqConvZExt2: return 2;
    opq_pkg::OpqConvSExt4, opq_pkg::OpqConvZExt4: return 4;
    default:                                      return 1;
  endcase
endfunction

// Result words for vl elements at the destination width, rounded up
function automatic int expected_words(input opq_pkg::vlen_t vl, input opq_pkg::eew_e sew);
  return (int'(vl) * (1 << int'(sew)) + 7) / 8;
endfunction

// Word k of one operand after widening to dst_bits
function automatic logic [63:0] widen_operand(input vrf_image_t img, input opq_pkg::vreg_t vs,
                                              input opq_pkg::opq_conv_e conv,
                                              input int dst_bits, input int k);
  int          factor;
  int          src_bits;
  bit          sign;
  logic [63:0] src;
  logic [63:0] elem;
  logic [63:0] res;
  factor   = widen_factor(conv);
  src_bits = dst_bits / factor;
  sign     = (conv == opq_pkg::OpqConvSExt2) || (conv == opq_pkg::OpqConvSExt4);
  src      = img[int'(vs) * `OPQ_WORDS_PER_VREG + k / factor];
  // Slice k mod factor, slice 0 in the low bits
  src      = src >> ((k % factor) * (64 / factor));
  res      = '0;
  for (int e = 0; e < 64 / dst_bits; e++) begin
    elem = (src >> (e * src_bits)) & low_mask(src_bits);
    if (sign && elem[src_bits-1]) begin
      elem = elem | ~low_mask(src_bits);
    end
    res = res | ((elem & low_mask(dst_bits)) << (e * dst_bits));
  end
  return res;
endfunction

// Expected result word k of a command, wrapping per element at sew
function automatic logic [63:0] expected_sum(input vrf_image_t img,
                                             input opq_pkg::vadd_cmd_t c, input int k);
  int          dst_bits;
  logic [63:0] a;
  logic [63:0] b;
  logic [63:0] sum;
  logic [63:0] res;
  dst_bits = 8 << int'(c.sew);
  a        = widen_operand(img, c.vs1, c.conv_a, dst_bits, k);
  b        = widen_operand(img, c.vs2, c.conv_b, dst_bits, k);
  res      = '0;
  for (int e = 0; e < 64 / dst_bits; e++) begin
    sum = (a >> (e * dst_bits)) + (b >> (e * dst_bits));
    res = res | ((sum & low_mask(dst_bits)) << (e * dst_bits));
  end
  return res;
endfunction

`endif

/* verification/tb_lane_operand_top.sv */
// Testbench for the lane operand path with preload, commands, result compare and watchdog
`timescale 1ns/1ps
`include "opq_cfg.svh"

module tb_lane_operand_top;

  localparam int unsigned NumTests = 120;
  localparam int unsigned Seed     = 32'h3a263440;
  localparam int unsigned NrWords  = `OPQ_NR_VREGS * `OPQ_WORDS_PER_VREG;

  `include "tb_lane_model.svh"

  logic               clk;
  logic               rst_n;
  logic               vrf_we;
  opq_pkg::vaddr_t    vrf_waddr;
  opq_pkg::elen_t     vrf_wdata;
  opq_pkg::vadd_cmd_t cmd;
  logic               cmd_valid;
  logic               cmd_ready;
  opq_pkg::elen_t     result;
  logic               result_valid;
  logic               result_ready;

  vrf_image_t         image;
  logic [63:0]        exp_q [$];
  int unsigned        delivered;

  lane_operand_top lane_operand_top_inst (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .vrf_we_i      (vrf_we),
    .vrf_waddr_i   (vrf_waddr),
    .vrf_wdata_i   (vrf_wdata),
    .cmd_i         (cmd),
    .cmd_valid_i   (cmd_valid),
    .cmd_ready_o   (cmd_ready),
    .result_o      (result),
    .result_valid_o(result_valid),
    .result_ready_i(result_ready)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "Simulation stopped");
    end
  endtask

  // Called one step after a rising edge, returns the same way
  task automatic preload_vrf();
    for (int a = 0; a < NrWords; a++) begin
      vrf_we    = 1'b1;
      vrf_waddr = opq_pkg::vaddr_t'(a);
      vrf_wdata = {$urandom, $urandom};
      image[a]  = vrf_wdata;
      @(posedge clk);
      #1;
    end
    vrf_we = 1'b0;
  endtask

  function automatic opq_pkg::opq_conv_e pick_conv(input opq_pkg::eew_e sew);
    opq_pkg::opq_conv_e conv;
    conv = opq_pkg::opq_conv_e'($urandom_range(4, 0));
    // Source elements stay at 8 bits or wider
    while (widen_factor(conv) > (1 << int'(sew))) begin
      conv = opq_pkg::opq_conv_e'($urandom_range(4, 0));
    end
    return conv;
  endfunction

  function automatic opq_pkg::vadd_cmd_t make_cmd(input int n);
    opq_pkg::vadd_cmd_t c;
    int                 min_factor;
    int                 src_bytes;
    c.vs1 = opq_pkg::vreg_t'($urandom_range(7, 0));
    c.vs2 = opq_pkg::vreg_t'($urandom_range(7, 0));
    if (n < 4) begin
      // Full registers without widening, one per width
      c.sew    = opq_pkg::eew_e'(n);
      c.conv_a = opq_pkg::OpqConvNone;
      c.conv_b = opq_pkg::OpqConvNone;
      c.vl     = opq_pkg::vlen_t'(32 >> n);
    end else begin
      c.sew      = opq_pkg::eew_e'($urandom_range(3, 0));
      c.conv_a   = pick_conv(c.sew);
      c.conv_b   = pick_conv(c.sew);
      min_factor = (widen_factor(c.conv_a) < widen_factor(c.conv_b)) ?
                   widen_factor(c.conv_a) : widen_factor(c.conv_b);
      src_bytes  = (1 << int'(c.sew)) / min_factor;
      // Reads stay inside one register
      c.vl       = opq_pkg::vlen_t'($urandom_range(32 / src_bytes, 1));
    end
    return c;
  endfunction

  task automatic send_cmd(input opq_pkg::vadd_cmd_t c);
    cmd       = c;
    cmd_valid = 1'b1;
    while (!cmd_ready) begin
      @(posedge clk);
      #1;
    end
    for (int k = 0; k < expected_words(c.vl, c.sew); k++) begin
      exp_q.push_back(expected_sum(image, c, k));
    end
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
    check_value("cmd_ready while reads are issuing", 64'(cmd_ready), 64'd0);
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0 || !cmd_ready) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Random back-pressure with occasional longer stalls
  task automatic drive_ready();
    int unsigned hold;
    forever begin
      @(posedge clk);
      #1;
      if ($urandom_range(15, 0) == 0) begin
        hold         = $urandom_range(8, 1);
        result_ready = 1'b0;
        repeat (hold) @(posedge clk);
        #1;
      end
      result_ready = ($urandom_range(3, 0) != 0);
    end
  endtask

  //////////////////////////////
  // Processes
  //////////////////////////////

  initial begin : stimulus
    void'($urandom(Seed));
    rst_n        = 1'b0;
    vrf_we       = 1'b0;
    vrf_waddr    = '0;
    vrf_wdata    = '0;
    cmd          = '0;
    cmd_valid    = 1'b0;
    result_ready = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_value("cmd_ready after reset", 64'(cmd_ready), 64'd1);
    check_value("result_valid after reset", 64'(result_valid), 64'd0);
    fork
      drive_ready();
    join_none
    preload_vrf();
    for (int n = 0; n < NumTests; n++) begin
      if (n == NumTests / 2) begin
        // New register contents once the first half has drained
        wait_drained();
        preload_vrf();
      end
      send_cmd(make_cmd(n));
    end
    wait_drained();
    repeat (20) @(posedge clk);
    #1;
    check_value("cmd_ready at end", 64'(cmd_ready), 64'd1);
    $display("%0d commands, %0d result words checked", NumTests, delivered);
    $display("NO ERRORS");
    $finish;
  end

  // Outputs are settled at the falling edge, transfer happens at the next rising edge
  initial begin : compare_results
    delivered = 0;
    forever begin
      @(negedge clk);
      if (rst_n && result_valid && result_ready) begin
        if (exp_q.size() == 0) begin
          abort_run("A result word was delivered with no command outstanding");
        end else begin
          check_value("result word", result, exp_q.pop_front());
          delivered++;
        end
      end
    end
  end

  initial begin : watchdog
    repeat (NumTests * 200) @(posedge clk);
    abort_run("Timeout: the lane stopped before all commands delivered their results");
  end

endmodule
